// ==== lsu.f ====
+incdir+rtl
rtl/lsu_pkg.sv
rtl/mem_req_if.sv
rtl/instr_decoder.sv
rtl/memory_reference_controller.sv
rtl/lsu_control.sv
rtl/data_memory.sv
rtl/load_formatter.sv
rtl/lsu_top.sv
tb/lsu_tb.sv

// ==== rtl/data_memory.sv ====
// on-chip word memory with byte lanes, written by stores and read by loads
`default_nettype none
`include "lsu_settings.svh"

module data_memory (
	input  logic        clk_i,
	mem_req_if.mem_mp   req,
	input  logic        we_i,
	input  logic        re_i,
	output logic [31:0] rdata_o
);

	logic [31:0]               mem [`LSU_MEM_WORDS];
	logic [`LSU_ADDR_BITS-1:0] word_idx;
	logic [31:0]               wdata;
	logic [3:0]                byte_en;

	// upper address bits wrap
	assign word_idx = req.addr[`LSU_ADDR_BITS+1:2];

	// ------------------------------------------------------------------
	// lane placement
	// ------------------------------------------------------------------

	// masked data sits in the low lanes, move it up to the offset
	assign wdata = req.data << {req.addr[1:0], 3'b000};

	always_comb begin
		case (req.func3)
			`RV32I_FUNC3_STORE_BYTE:  byte_en = 4'b0001 << req.addr[1:0];
			`RV32I_FUNC3_STORE_HWORD: byte_en = 4'b0011 << req.addr[1:0];
			`RV32I_FUNC3_STORE_WORD:  byte_en = 4'b1111;
			// no lanes for bad widths
			default:                  byte_en = 4'b0000;
		endcase
	end

	// ------------------------------------------------------------------
	// array
	// ------------------------------------------------------------------

	always_ff @(posedge clk_i) begin
		if (we_i) begin
			for (int b = 0; b < 4; b++) begin
				if (byte_en[b]) begin
					mem[word_idx][8*b +: 8] <= wdata[8*b +: 8];
				end
			end
		end
		// whole word, slicing is done downstream
		if (re_i) begin
			rdata_o <= mem[word_idx];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/instr_decoder.sv ====
// combinational decode of the latched instruction into class, func3 and immediate
`default_nettype none
`include "lsu_settings.svh"

module instr_decoder
	import lsu_pkg::*;
(
	input  instr_word_t  instr_i,
	output logic [8:0]   encoding_o,
	output logic [2:0]   func3_o,
	output logic [31:0]  immediate_o
);

	// ------------------------------------------------------------------
	// opcode to one-hot class
	// ------------------------------------------------------------------

	// opcode lives in the same bits for both views
	always_comb begin
		case (instr_i.i_view.opcode)
			`OPCODE_LUI:    encoding_o = `ENCODING_LUI;
			`OPCODE_AUIPC:  encoding_o = `ENCODING_AUIPC;
			`OPCODE_JAL:    encoding_o = `ENCODING_JAL;
			`OPCODE_JALR:   encoding_o = `ENCODING_JALR;
			`OPCODE_BRANCH: encoding_o = `ENCODING_BRANCH;
			`OPCODE_LOAD:   encoding_o = `ENCODING_LOAD;
			`OPCODE_STORE:  encoding_o = `ENCODING_STORE;
			`OPCODE_OPIMM:  encoding_o = `ENCODING_OPIMM;
			`OPCODE_OP:     encoding_o = `ENCODING_OP;
			// unknown opcode
			default:        encoding_o = 9'b0;
		endcase
	end

	// func3 also shared between views
	assign func3_o = instr_i.i_view.func3;

	// ------------------------------------------------------------------
	// immediate
	// ------------------------------------------------------------------

	always_comb begin
		case (instr_i.i_view.opcode)
			// loads take the 12-bit i-type field
			`OPCODE_LOAD: begin
				immediate_o = {{20{instr_i.i_view.imm[11]}}, instr_i.i_view.imm};
			end
			// stores glue the split s-type halves back together
			`OPCODE_STORE: begin
				immediate_o = {{20{instr_i.s_view.imm_hi[6]}},
					instr_i.s_view.imm_hi, instr_i.s_view.imm_lo};
			end
			// no address for other classes
			default: immediate_o = 32'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/load_formatter.sv ====
// slices the read word per offset and width, extends it and registers the load result
`default_nettype none
`include "lsu_settings.svh"

module load_formatter (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        capture_i,
	input  logic [31:0] rdata_i,
	input  logic [2:0]  func3_i,
	input  logic [1:0]  offset_i,
	output logic [31:0] load_data_o
);

	logic [7:0]  sel_byte;
	logic [15:0] sel_hword;
	logic [31:0] formatted;

	// byte at any offset, halfword at 0 or 2
	assign sel_byte  = rdata_i[{offset_i, 3'b000} +: 8];
	assign sel_hword = offset_i[1] ? rdata_i[31:16] : rdata_i[15:0];

	always_comb begin
		case (func3_i)
			`RV32I_FUNC3_LOAD_BYTE:    formatted = {{24{sel_byte[7]}}, sel_byte};
			`RV32I_FUNC3_LOAD_BYTE_U:  formatted = {24'b0, sel_byte};
			`RV32I_FUNC3_LOAD_HWORD:   formatted = {{16{sel_hword[15]}}, sel_hword};
			`RV32I_FUNC3_LOAD_HWORD_U: formatted = {16'b0, sel_hword};
			// word, bad codes never reach capture
			default:                   formatted = rdata_i;
		endcase
	end

	// holds the last load result between loads
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			load_data_o <= 32'b0;
		end else if (capture_i) begin
			load_data_o <= formatted;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/lsu_control.sv ====
// lsu sequencing FSM, latches an issue, drives memory strobes and completion pulses
`default_nettype none
`include "lsu_settings.svh"

module lsu_control
	import lsu_pkg::*;
(
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        issue_i,
	input  logic [31:0] instr_i,
	input  logic [31:0] rs1_i,
	input  logic [31:0] rs2_i,
	mem_req_if.seq_mp   req,
	output instr_word_t instr_q_o,
	output logic [31:0] rs1_q_o,
	output logic [31:0] rs2_q_o,
	output logic        mem_we_o,
	output logic        mem_re_o,
	output logic        load_fin_o,
	output logic        done_o,
	output logic        load_valid_o,
	output logic        busy_o,
	output logic        exc_valid_o,
	output logic [2:0]  exc_code_o
);

	localparam logic [1:0] ST_IDLE     = 2'd0;
	localparam logic [1:0] ST_ACCESS   = 2'd1;
	localparam logic [1:0] ST_LOAD_FIN = 2'd2;

	logic [1:0] state_q;
	logic       word_acc;
	logic       hword_acc;
	logic       fault;

	// ------------------------------------------------------------------
	// issue latch
	// ------------------------------------------------------------------

	// only taken while idle, so a busy issue is dropped
	always_ff @(posedge clk_i) begin
		if (state_q == ST_IDLE && issue_i) begin
			instr_q_o <= instr_i;
			rs1_q_o   <= rs1_i;
			rs2_q_o   <= rs2_i;
		end
	end

	// ------------------------------------------------------------------
	// fault classification
	// ------------------------------------------------------------------

	// store func3 codes equal the load ones
	assign word_acc  = (req.func3 == `RV32I_FUNC3_LOAD_WORD);
	assign hword_acc = (req.func3 == `RV32I_FUNC3_LOAD_HWORD) ||
		(req.func3 == `RV32I_FUNC3_LOAD_HWORD_U);

	// byte accesses never misalign
	assign fault = (req.flag_load | req.flag_store) &
		(req.exception[2] |
		(word_acc & (req.exception[1] | req.exception[0])) |
		(hword_acc & req.exception[0]));

	// strobes only in the access cycle, blocked on a fault
	assign mem_we_o   = (state_q == ST_ACCESS) & req.flag_store & ~fault;
	assign mem_re_o   = (state_q == ST_ACCESS) & req.flag_load & ~fault;
	assign load_fin_o = (state_q == ST_LOAD_FIN);
	assign busy_o     = (state_q != ST_IDLE);

	// ------------------------------------------------------------------
	// state and completion pulses
	// ------------------------------------------------------------------

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q      <= ST_IDLE;
			done_o       <= 1'b0;
			load_valid_o <= 1'b0;
			exc_valid_o  <= 1'b0;
			exc_code_o   <= 3'b0;
		end else begin
			// pulses last one cycle
			done_o       <= 1'b0;
			load_valid_o <= 1'b0;
			exc_valid_o  <= 1'b0;
			case (state_q)
				ST_IDLE: begin
					if (issue_i) begin
						state_q <= ST_ACCESS;
					end
				end
				ST_ACCESS: begin
					if (mem_re_o) begin
						// read word lands this edge, format next
						state_q <= ST_LOAD_FIN;
					end else begin
						// store, fault or non-memory retires here
						state_q <= ST_IDLE;
						done_o  <= 1'b1;
						if (fault) begin
							exc_valid_o <= 1'b1;
							exc_code_o  <= req.exception;
						end
					end
				end
				ST_LOAD_FIN: begin
					state_q      <= ST_IDLE;
					done_o       <= 1'b1;
					load_valid_o <= 1'b1;
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/lsu_pkg.sv ====
// shared lsu types, wildcard-imported by modules that handle the raw instruction word
`default_nettype none

package lsu_pkg;

	// ------------------------------------------------------------------
	// instruction word, seen as i-type or s-type
	// ------------------------------------------------------------------

	// both views overlay the same 32 bits
	// opcode, func3 and rs1 sit at the same place in either view
	typedef union packed {
		// i-type, used by loads
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  func3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i_view;

		// s-type, used by stores
		// immediate split around rs2 and rs1
		struct packed {
			logic [6:0]  imm_hi;
			logic [4:0]  rs2;
			logic [4:0]  rs1;
			logic [2:0]  func3;
			logic [4:0]  imm_lo;
			logic [6:0]  opcode;
		} s_view;
	} instr_word_t;

endpackage

`default_nettype wire

// ==== rtl/lsu_settings.svh ====
// encodings, opcodes, func3 codes and memory depth for the lsu, included by rtl and testbench
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// one-hot instruction class, msb first, zero means unrecognized
`define ENCODING_LUI    9'b100000000
`define ENCODING_AUIPC  9'b010000000
`define ENCODING_JAL    9'b001000000
`define ENCODING_JALR   9'b000100000
`define ENCODING_BRANCH 9'b000010000
`define ENCODING_LOAD   9'b000001000
`define ENCODING_STORE  9'b000000100
`define ENCODING_OPIMM  9'b000000010
`define ENCODING_OP     9'b000000001

// rv32i major opcodes
`define OPCODE_LUI    7'b0110111
`define OPCODE_AUIPC  7'b0010111
`define OPCODE_JAL    7'b1101111
`define OPCODE_JALR   7'b1100111
`define OPCODE_BRANCH 7'b1100011
`define OPCODE_LOAD   7'b0000011
`define OPCODE_STORE  7'b0100011
`define OPCODE_OPIMM  7'b0010011
`define OPCODE_OP     7'b0110011

// func3 of the memory instructions
`define RV32I_FUNC3_STORE_BYTE  3'b000
`define RV32I_FUNC3_STORE_HWORD 3'b001
`define RV32I_FUNC3_STORE_WORD  3'b010
`define RV32I_FUNC3_LOAD_BYTE   3'b000
`define RV32I_FUNC3_LOAD_HWORD  3'b001
`define RV32I_FUNC3_LOAD_WORD   3'b010
`define RV32I_FUNC3_LOAD_BYTE_U 3'b100
`define RV32I_FUNC3_LOAD_HWORD_U 3'b101

// data memory depth in words, index width must match
`define LSU_MEM_WORDS 256
`define LSU_ADDR_BITS 8

`endif

// ==== rtl/lsu_top.sv ====
// top level of the rv32i load/store unit, plain ports around control and datapath
`default_nettype none

module lsu_top
	import lsu_pkg::*;
(
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        issue_i,
	input  logic [31:0] instr_i,
	input  logic [31:0] rs1_i,
	input  logic [31:0] rs2_i,
	output logic        busy_o,
	output logic        done_o,
	output logic        load_valid_o,
	output logic [31:0] load_data_o,
	output logic        exc_valid_o,
	output logic [2:0]  exc_code_o
);

	// latched instruction and operands
	instr_word_t instr_q;
	logic [31:0] rs1_q;
	logic [31:0] rs2_q;
	// decode results
	logic [8:0]  encoding;
	logic [2:0]  func3;
	logic [31:0] immediate;
	// memory strobes and read path
	logic        mem_we;
	logic        mem_re;
	logic        load_fin;
	logic [31:0] rdata;

	mem_req_if req_if ();

	// ------------------------------------------------------------------
	// control
	// ------------------------------------------------------------------

	lsu_control u_control (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.issue_i      (issue_i),
		.instr_i      (instr_i),
		.rs1_i        (rs1_i),
		.rs2_i        (rs2_i),
		.req          (req_if.seq_mp),
		.instr_q_o    (instr_q),
		.rs1_q_o      (rs1_q),
		.rs2_q_o      (rs2_q),
		.mem_we_o     (mem_we),
		.mem_re_o     (mem_re),
		.load_fin_o   (load_fin),
		.done_o       (done_o),
		.load_valid_o (load_valid_o),
		.busy_o       (busy_o),
		.exc_valid_o  (exc_valid_o),
		.exc_code_o   (exc_code_o)
	);

	// ------------------------------------------------------------------
	// datapath
	// ------------------------------------------------------------------

	instr_decoder u_decoder (
		.instr_i     (instr_q),
		.encoding_o  (encoding),
		.func3_o     (func3),
		.immediate_o (immediate)
	);

	memory_reference_controller u_mrc (
		.encoding_i     (encoding),
		.func3_i        (func3),
		.src1_operand_i (rs1_q),
		.src2_operand_i (rs2_q),
		.immediate_i    (immediate),
		.req            (req_if.ctrl_mp)
	);

	data_memory u_mem (
		.clk_i   (clk_i),
		.req     (req_if.mem_mp),
		.we_i    (mem_we),
		.re_i    (mem_re),
		.rdata_o (rdata)
	);

	// offset and width stay valid while the instruction is held
	load_formatter u_fmt (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.capture_i   (load_fin),
		.rdata_i     (rdata),
		.func3_i     (req_if.func3),
		.offset_i    (req_if.addr[1:0]),
		.load_data_o (load_data_o)
	);

endmodule

`default_nettype wire

// ==== rtl/mem_req_if.sv ====
// decoded memory request shared by the reference controller, the control FSM and the memory
`default_nettype none

interface mem_req_if;

	// request flags
	logic        flag_load;
	logic        flag_store;
	// target address and masked store data
	logic [31:0] addr;
	logic [31:0] data;
	// access width and sign, passed through
	logic [2:0]  func3;
	// [2] unknown func3, [1] addr[1] set, [0] addr[0] set
	logic [2:0]  exception;

	// producer side
	modport ctrl_mp (output flag_load, flag_store, addr, data, func3, exception);
	// FSM classifies the request
	modport seq_mp (input flag_load, flag_store, func3, exception);
	// memory only needs location, data and width
	modport mem_mp (input addr, data, func3);

endinterface

`default_nettype wire

// ==== rtl/memory_reference_controller.sv ====
// computes target address, store data and exception vector of a load or store
`default_nettype none
`include "lsu_settings.svh"

module memory_reference_controller (
	input  logic [8:0]  encoding_i,
	input  logic [2:0]  func3_i,
	input  logic [31:0] src1_operand_i,
	input  logic [31:0] src2_operand_i,
	input  logic [31:0] immediate_i,
	mem_req_if.ctrl_mp  req
);

	logic        flag_load;
	logic        flag_store;
	logic [31:0] addr_target;
	logic [31:0] data_target;
	logic        func3_bad;

	// ------------------------------------------------------------------
	// request decode
	// ------------------------------------------------------------------

	always_comb begin
		// idle defaults, also for non-memory classes
		flag_load   = 1'b0;
		flag_store  = 1'b0;
		addr_target = 32'b0;
		data_target = 32'b0;
		func3_bad   = 1'b0;

		case (encoding_i)
			`ENCODING_LOAD: begin
				flag_load   = 1'b1;
				addr_target = src1_operand_i + immediate_i;
				// five legal load widths
				case (func3_i)
					`RV32I_FUNC3_LOAD_BYTE,
					`RV32I_FUNC3_LOAD_HWORD,
					`RV32I_FUNC3_LOAD_WORD,
					`RV32I_FUNC3_LOAD_BYTE_U,
					`RV32I_FUNC3_LOAD_HWORD_U: func3_bad = 1'b0;
					default:                   func3_bad = 1'b1;
				endcase
			end

			`ENCODING_STORE: begin
				flag_store  = 1'b1;
				addr_target = src1_operand_i + immediate_i;
				// keep only the bytes being stored
				case (func3_i)
					`RV32I_FUNC3_STORE_BYTE:  data_target = src2_operand_i & 32'h0000_00ff;
					`RV32I_FUNC3_STORE_HWORD: data_target = src2_operand_i & 32'h0000_ffff;
					`RV32I_FUNC3_STORE_WORD:  data_target = src2_operand_i;
					default:                  func3_bad = 1'b1;
				endcase
			end

			default: func3_bad = 1'b0;
		endcase
	end

	// ------------------------------------------------------------------
	// interface drive
	// ------------------------------------------------------------------

	assign req.flag_load  = flag_load;
	assign req.flag_store = flag_store;
	assign req.addr       = addr_target;
	assign req.data       = data_target;
	assign req.func3      = func3_i;
	// alignment bits only meaningful on an access
	// width check happens in the FSM
	assign req.exception  = {func3_bad,
		(flag_load | flag_store) & addr_target[1],
		(flag_load | flag_store) & addr_target[0]};

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the lsu testbench with verilator, run it, judge the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f lsu.f --top-module lsu_tb -o lsu_sim

# the run stops with a nonzero status on a failure, the log decides
./obj_dir/lsu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Some tests failed" sim.log; then
	echo "simulation FAILED"
	exit 1
fi
echo "simulation PASSED"

// ==== tb/lsu_tb.sv ====
// self-checking testbench for lsu_top, compiled from the project root through lsu.f
`default_nettype none
`include "lsu_settings.svh"

module lsu_tb;

	timeunit 1ns;
	timeprecision 100ps;

	// how an accepted instruction retires
	localparam logic [1:0] KIND_SHORT = 2'd0;
	localparam logic [1:0] KIND_FAULT = 2'd1;
	localparam logic [1:0] KIND_LOAD  = 2'd2;

	logic        clk_i;
	logic        rst_i;
	logic        issue_i;
	logic [31:0] instr_i;
	logic [31:0] rs1_i;
	logic [31:0] rs2_i;
	logic        busy_o;
	logic        done_o;
	logic        load_valid_o;
	logic [31:0] load_data_o;
	logic        exc_valid_o;
	logic [2:0]  exc_code_o;

	// reference memory, one entry per byte
	logic [7:0]  model [4*`LSU_MEM_WORDS];

	// prediction for the instruction on the inputs
	logic [1:0]  pred_kind;
	logic [2:0]  pred_exc;
	logic [31:0] pred_data;

	// expectation pipeline, stage n holds the issue n edges back
	logic        rst_seen = 1'b0;
	logic        started = 1'b0;
	logic [3:1]  stage_q;
	logic [1:0]  kind_q [1:3];
	logic [2:0]  exc_q [1:2];
	logic [31:0] data_q [1:3];
	logic        exp_busy;
	logic        exp_done;
	logic        exp_load;
	logic        exp_exc;

	lsu_top UUT (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.issue_i      (issue_i),
		.instr_i      (instr_i),
		.rs1_i        (rs1_i),
		.rs2_i        (rs2_i),
		.busy_o       (busy_o),
		.done_o       (done_o),
		.load_valid_o (load_valid_o),
		.load_data_o  (load_data_o),
		.exc_valid_o  (exc_valid_o),
		.exc_code_o   (exc_code_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #50 clk_i = ~clk_i;
	end

	// ----------------------------------------------------------------------
	// expectation pipeline
	// ----------------------------------------------------------------------

	always @(posedge clk_i) begin
		if (rst_i) begin
			rst_seen <= 1'b1;
			started  <= 1'b0;
			stage_q  <= 3'b000;
		end else begin
			stage_q   <= {stage_q[2:1], issue_i && !exp_busy};
			kind_q[1] <= pred_kind;
			kind_q[2] <= kind_q[1];
			kind_q[3] <= kind_q[2];
			exc_q[1]  <= pred_exc;
			exc_q[2]  <= exc_q[1];
			data_q[1] <= pred_data;
			data_q[2] <= data_q[1];
			data_q[3] <= data_q[2];
			if (issue_i && !exp_busy) begin
				started <= 1'b1;
			end
		end
	end

	// busy from the issue edge until the retire edge
	assign exp_busy = stage_q[1] || (stage_q[2] && kind_q[2] == KIND_LOAD);

	// loads retire two edges after issue, all else one
	assign exp_load = stage_q[3] && kind_q[3] == KIND_LOAD;
	assign exp_exc  = stage_q[2] && kind_q[2] == KIND_FAULT;
	assign exp_done = exp_load || (stage_q[2] && kind_q[2] != KIND_LOAD);

	// ----------------------------------------------------------------------
	// checks, sampled on the falling edge where outputs are settled
	// ----------------------------------------------------------------------

	idle_after_reset: assert property (@(negedge clk_i) disable iff (!rst_seen)
		!started |-> (!busy_o && !done_o && !load_valid_o && !exc_valid_o &&
		load_data_o == 32'b0 && exc_code_o == 3'b0))
		else abort_run($sformatf("outputs not idle before the first issue at %0t", $time));

	busy_value: assert property (@(negedge clk_i) disable iff (rst_i) busy_o == exp_busy)
		else abort_run($sformatf("mismatch at %0t: busy_o got %b expected %b",
			$time, busy_o, exp_busy));

	done_latency: assert property (@(negedge clk_i) disable iff (rst_i) done_o == exp_done)
		else abort_run($sformatf("mismatch at %0t: done_o got %b expected %b",
			$time, done_o, exp_done));

	load_valid_latency: assert property (@(negedge clk_i) disable iff (rst_i)
		load_valid_o == exp_load)
		else abort_run($sformatf("mismatch at %0t: load_valid_o got %b expected %b",
			$time, load_valid_o, exp_load));

	exc_valid_latency: assert property (@(negedge clk_i) disable iff (rst_i)
		exc_valid_o == exp_exc)
		else abort_run($sformatf("mismatch at %0t: exc_valid_o got %b expected %b",
			$time, exc_valid_o, exp_exc));

	load_data_value: assert property (@(negedge clk_i) disable iff (rst_i)
		load_valid_o |-> load_data_o == data_q[3])
		else abort_run($sformatf("mismatch at %0t: load_data_o got %h expected %h",
			$time, load_data_o, data_q[3]));

	exc_code_value: assert property (@(negedge clk_i) disable iff (rst_i)
		exc_valid_o |-> exc_code_o == exc_q[2])
		else abort_run($sformatf("mismatch at %0t: exc_code_o got %b expected %b",
			$time, exc_code_o, exc_q[2]));

	// stores, faults and other classes leave the result register alone
	no_writeback: assert property (@(negedge clk_i) disable iff (rst_i)
		!load_valid_o |-> $stable(load_data_o))
		else abort_run($sformatf("load_data_o changed without a load at %0t", $time));

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "stopping at first error");
	endtask

	function automatic logic [31:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	// rd x2, base register x1
	function automatic logic [31:0] load_instr(input logic [2:0] f3, input logic [11:0] imm);
		return {imm, 5'd1, f3, 5'd2, `OPCODE_LOAD};
	endfunction

	// data from x3, base register x1
	function automatic logic [31:0] store_instr(input logic [2:0] f3, input logic [11:0] imm);
		return {imm[11:5], 5'd3, 5'd1, f3, imm[4:0], `OPCODE_STORE};
	endfunction

	// word i of the initial image, every index bit matters
	function automatic logic [31:0] fill_value(input int i);
		return (32'h9e37_79b9 * 32'(i + 1)) ^ 32'(i);
	endfunction

	function automatic logic [31:0] predict_load(input logic [2:0] f3, input logic [31:0] addr);
		int idx;
		idx = int'(addr[`LSU_ADDR_BITS+1:0]);
		case (f3)
			`RV32I_FUNC3_LOAD_BYTE:    return {{24{model[idx][7]}}, model[idx]};
			`RV32I_FUNC3_LOAD_BYTE_U:  return {24'b0, model[idx]};
			`RV32I_FUNC3_LOAD_HWORD:   return {{16{model[idx+1][7]}}, model[idx+1], model[idx]};
			`RV32I_FUNC3_LOAD_HWORD_U: return {16'b0, model[idx+1], model[idx]};
			default: return {model[idx+3], model[idx+2], model[idx+1], model[idx]};
		endcase
	endfunction

	task automatic update_model(input logic [2:0] f3, input logic [31:0] addr,
		input logic [31:0] data);
		int idx;
		idx = int'(addr[`LSU_ADDR_BITS+1:0]);
		model[idx] = data[7:0];
		if (f3 != `RV32I_FUNC3_STORE_BYTE) begin
			model[idx+1] = data[15:8];
		end
		if (f3 == `RV32I_FUNC3_STORE_WORD) begin
			model[idx+2] = data[23:16];
			model[idx+3] = data[31:24];
		end
	endtask

	// predicts, issues at a falling edge and waits for done_o
	task automatic run_instr(input logic [31:0] instr, input logic [31:0] rs1,
		input logic [31:0] rs2, input logic poke_busy);
		logic [6:0]  opc;
		logic [2:0]  f3;
		logic [31:0] imm;
		logic [31:0] addr;
		logic        is_mem;
		logic        bad_f3;
		logic        word_acc;
		logic        half_acc;
		logic        fault;
		int          waited;
		opc    = instr[6:0];
		f3     = instr[14:12];
		is_mem = (opc == `OPCODE_LOAD) || (opc == `OPCODE_STORE);
		// s-type immediate is split around rs2
		imm    = (opc == `OPCODE_STORE) ? sext12({instr[31:25], instr[11:7]}) :
			sext12(instr[31:20]);
		addr   = rs1 + imm;
		bad_f3 = 1'b0;
		if (opc == `OPCODE_LOAD) begin
			case (f3)
				3'd0, 3'd1, 3'd2, 3'd4, 3'd5: bad_f3 = 1'b0;
				default:                      bad_f3 = 1'b1;
			endcase
		end else if (opc == `OPCODE_STORE) begin
			bad_f3 = (f3 > `RV32I_FUNC3_STORE_WORD);
		end
		word_acc  = (f3 == `RV32I_FUNC3_LOAD_WORD);
		half_acc  = (f3 == `RV32I_FUNC3_LOAD_HWORD) || (f3 == `RV32I_FUNC3_LOAD_HWORD_U);
		fault     = is_mem && (bad_f3 || (word_acc && addr[1:0] != 2'b00) ||
			(half_acc && addr[0]));
		pred_exc  = {bad_f3, is_mem && addr[1], is_mem && addr[0]};
		pred_data = 32'b0;
		if (fault) begin
			pred_kind = KIND_FAULT;
		end else if (opc == `OPCODE_LOAD) begin
			pred_kind = KIND_LOAD;
			pred_data = predict_load(f3, addr);
		end else begin
			pred_kind = KIND_SHORT;
			if (is_mem) begin
				update_model(f3, addr, rs2);
			end
		end
		issue_i = 1'b1;
		instr_i = instr;
		rs1_i   = rs1;
		rs2_i   = rs2;
		@(negedge clk_i);
		issue_i = 1'b0;
		if (poke_busy) begin
			// would clobber the loaded word if taken
			issue_i = 1'b1;
			instr_i = store_instr(`RV32I_FUNC3_STORE_WORD, 12'h000);
			rs1_i   = {addr[31:2], 2'b00};
			rs2_i   = ~rs2;
			@(negedge clk_i);
			issue_i = 1'b0;
		end
		waited = 0;
		while (!done_o && waited < 20) begin
			@(negedge clk_i);
			waited++;
		end
		if (!done_o) begin
			abort_run("timeout: done_o did not pulse within 20 cycles of an issue");
		end
	endtask

	// random immediate, base register chosen to hit addr
	task automatic store_at(input logic [2:0] f3, input logic [31:0] addr,
		input logic [31:0] data);
		logic [11:0] imm;
		imm = 12'($urandom);
		run_instr(store_instr(f3, imm), addr - sext12(imm), data, 1'b0);
	endtask

	task automatic load_from(input logic [2:0] f3, input logic [31:0] addr);
		logic [11:0] imm;
		imm = 12'($urandom);
		run_instr(load_instr(f3, imm), addr - sext12(imm), $urandom, 1'b0);
	endtask

	// ----------------------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------------------

	initial begin
		logic [31:0] base;
		void'($urandom(32'h0ead_dfcd));
		rst_i      = 1'b1;
		issue_i    = 1'b0;
		instr_i    = 32'b0;
		rs1_i      = 32'b0;
		rs2_i      = 32'b0;
		pred_kind  = KIND_SHORT;
		pred_exc   = 3'b0;
		pred_data  = 32'b0;
		repeat (16) @(posedge clk_i);
		@(negedge clk_i);
		rst_i = 1'b0;
		// quiet stretch for the idle check
		repeat (8) @(negedge clk_i);

		// known image in every word
		for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
			store_at(`RV32I_FUNC3_STORE_WORD, 32'(4 * i), fill_value(i));
		end

		// aligned word traffic
		for (int n = 0; n < 48; n++) begin
			base = $urandom & ~32'h3;
			store_at(`RV32I_FUNC3_STORE_WORD, base, $urandom);
			load_from(`RV32I_FUNC3_LOAD_WORD, base);
			load_from(`RV32I_FUNC3_LOAD_WORD, $urandom & ~32'h3);
		end

		// byte and halfword lanes, signed and unsigned reads
		for (int n = 0; n < 16; n++) begin
			base = $urandom & ~32'h3;
			for (int off = 0; off < 4; off++) begin
				store_at(`RV32I_FUNC3_STORE_BYTE, base + 32'(off), $urandom);
			end
			store_at(`RV32I_FUNC3_STORE_HWORD, base + ($urandom & 32'h2), $urandom);
			for (int off = 0; off < 4; off++) begin
				load_from(`RV32I_FUNC3_LOAD_BYTE, base + 32'(off));
				load_from(`RV32I_FUNC3_LOAD_BYTE_U, base + 32'(off));
			end
			for (int off = 0; off < 4; off += 2) begin
				load_from(`RV32I_FUNC3_LOAD_HWORD, base + 32'(off));
				load_from(`RV32I_FUNC3_LOAD_HWORD_U, base + 32'(off));
			end
			load_from(`RV32I_FUNC3_LOAD_WORD, base);
		end

		// misaligned words and halfwords fault, memory keeps its value
		for (int n = 0; n < 4; n++) begin
			base = $urandom & ~32'h3;
			for (int off = 1; off < 4; off++) begin
				store_at(`RV32I_FUNC3_STORE_WORD, base + 32'(off), $urandom);
				load_from(`RV32I_FUNC3_LOAD_WORD, base + 32'(off));
			end
			for (int off = 1; off < 4; off += 2) begin
				store_at(`RV32I_FUNC3_STORE_HWORD, base + 32'(off), $urandom);
				load_from(`RV32I_FUNC3_LOAD_HWORD, base + 32'(off));
				load_from(`RV32I_FUNC3_LOAD_HWORD_U, base + 32'(off));
			end
			load_from(`RV32I_FUNC3_LOAD_WORD, base);
		end

		// unknown widths
		for (int f = 3; f < 8; f++) begin
			store_at(3'(f), $urandom, $urandom);
		end
		load_from(3'd3, $urandom);
		load_from(3'd6, $urandom);
		load_from(3'd7, $urandom);

		// non-memory classes retire with done only
		run_instr({7'b0, 5'd3, 5'd1, 3'b000, 5'd2, `OPCODE_OP}, $urandom, $urandom, 1'b0);
		run_instr({20'habcde, 5'd2, `OPCODE_LUI}, $urandom, $urandom, 1'b0);

		// second issue while busy is dropped
		base = $urandom & ~32'h3;
		store_at(`RV32I_FUNC3_STORE_WORD, base, $urandom);
		run_instr(load_instr(`RV32I_FUNC3_LOAD_WORD, 12'h000), base, $urandom, 1'b1);
		load_from(`RV32I_FUNC3_LOAD_WORD, base);

		repeat (4) @(negedge clk_i);
		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire
